/* include/ray_box_macros.svh */
`ifndef RAY_BOX_MACROS_SVH
`define RAY_BOX_MACROS_SVH

////////////////////
// number formats
////////////////////

// integer coordinate, two's complement
`define COORD_W 16

// inverse of the ray direction, signed fixed point
`define INV_W 16

// fraction bits of the inverse, carried over into every distance
`define INV_FRAC 8

// distance holds a 17 bit difference times a 16 bit inverse plus headroom
`define T_W 34

////////////////////
// pipeline
////////////////////

// input edge to out_valid
`define PIPE_LAT 4

`endif

/* logic/ray_box_pkg.sv */
`include "ray_box_macros.svh"

package ray_box_pkg;

	////////////////////
	// scalar types
	////////////////////

	typedef logic signed [`COORD_W-1:0] coord_t; // box corner or origin
	typedef logic signed [`INV_W-1:0] inv_t; // 1/dir, INV_FRAC fraction bits
	typedef logic signed [`T_W-1:0] tdist_t; // distance along the ray

	// direction class of one axis, decides which product is entry
	typedef enum logic [1:0] {
		AXIS_POS = 2'd0, // inverse zero or positive
		AXIS_NEG = 2'd1, // inverse negative
		AXIS_PARALLEL = 2'd2 // parallel flag set, no limit from this axis
	} axis_dir_t;

	////////////////////
	// query and result
	////////////////////

	// one axis of a ray/box pair
	typedef struct packed {
		coord_t origin;
		coord_t box_min;
		coord_t box_max;
		inv_t inv;
		logic parallel; // ray does not move along this axis
	} axis_query_t;

	// full query, one slice per axis
	typedef struct packed {
		axis_query_t qx;
		axis_query_t qy;
		axis_query_t qz;
	} ray_query_t;

	// distance interval of one slab
	typedef struct packed {
		tdist_t t_enter;
		tdist_t t_exit;
		logic outside; // parallel axis with origin out of its slab
	} axis_span_t;

	// bounds of a parallel slab
	localparam tdist_t T_NEG_INF = {1'b1, {(`T_W-1){1'b0}}};
	localparam tdist_t T_POS_INF = {1'b0, {(`T_W-1){1'b1}}};

endpackage

/* logic/axis_slab.sv */
`timescale 1ns/1ps
`include "ray_box_macros.svh"

module axis_slab
	import ray_box_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input axis_query_t axq,
	output axis_span_t span,
	output logic span_valid
);

	localparam int DIFF_W = `COORD_W + 1; // corner minus origin never overflows
	localparam int PROD_W = DIFF_W + `INV_W; // full product, no rounding

	////////////////////
	// stage 1 inputs
	////////////////////

	logic signed [DIFF_W-1:0] diff_min; // box_min - origin
	logic signed [DIFF_W-1:0] diff_max; // box_max - origin
	axis_dir_t dir_class;
	logic below_min;
	logic above_max;
	logic outside_d;

	// sign extension comes from the 17 bit context
	assign diff_min = axq.box_min - axq.origin;
	assign diff_max = axq.box_max - axq.origin;

	always_comb begin
		if (axq.parallel) begin
			dir_class = AXIS_PARALLEL; // flag wins over the inverse
		end else if (axq.inv[`INV_W-1]) begin
			dir_class = AXIS_NEG;
		end else begin
			dir_class = AXIS_POS; // zero inverse lands here too
		end
	end

	assign below_min = axq.origin < axq.box_min;
	assign above_max = axq.origin > axq.box_max;

	// only a parallel axis can rule the ray out on its own
	assign outside_d = axq.parallel && (below_min || above_max);

	////////////////////
	// stage 1 registers
	////////////////////

	logic s1_valid;
	logic signed [DIFF_W-1:0] s1_diff_min;
	logic signed [DIFF_W-1:0] s1_diff_max;
	inv_t s1_inv;
	axis_dir_t s1_dir;
	logic s1_outside;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_diff_min <= diff_min;
			s1_diff_max <= diff_max;
			s1_inv <= axq.inv;
			s1_dir <= dir_class;
			s1_outside <= outside_d;
		end
	end

	////////////////////
	// stage 2 products
	////////////////////

	logic signed [PROD_W-1:0] prod_min; // distance to the min plane
	logic signed [PROD_W-1:0] prod_max; // distance to the max plane
	tdist_t t_at_min;
	tdist_t t_at_max;
	tdist_t enter_d;
	tdist_t exit_d;

	assign prod_min = s1_diff_min * s1_inv; // both signed, full width
	assign prod_max = s1_diff_max * s1_inv;

	assign t_at_min = prod_min; // widen to T_W, sign kept
	assign t_at_max = prod_max;

	// entry is the nearer plane in the direction of travel
	always_comb begin
		enter_d = T_NEG_INF;
		exit_d = T_POS_INF;
		case (s1_dir)
			AXIS_POS: begin
				enter_d = t_at_min;
				exit_d = t_at_max;
			end
			AXIS_NEG: begin
				enter_d = t_at_max; // moving down, max plane first
				exit_d = t_at_min;
			end
			default: begin
				enter_d = T_NEG_INF; // parallel, slab spans the whole ray
				exit_d = T_POS_INF;
			end
		endcase
	end

	////////////////////
	// stage 2 registers
	////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			span_valid <= 1'b0;
		end else begin
			span_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			span.t_enter <= enter_d;
			span.t_exit <= exit_d;
			span.outside <= s1_outside;
		end
	end

endmodule

/* logic/interval_intersect.sv */
`timescale 1ns/1ps
`include "ray_box_macros.svh"

module interval_intersect
	import ray_box_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic span_valid,
	input axis_span_t span_x,
	input axis_span_t span_y,
	input axis_span_t span_z,
	output logic out_valid,
	output logic hit
);

	localparam tdist_t T_ZERO = '0;

	function automatic tdist_t t_max(input tdist_t a, input tdist_t b);
		t_max = (a > b) ? a : b;
	endfunction

	function automatic tdist_t t_min(input tdist_t a, input tdist_t b);
		t_min = (a < b) ? a : b;
	endfunction

	////////////////////
	// stage 3 reduce
	////////////////////

	tdist_t near_xy;
	tdist_t far_xy;
	tdist_t near_d;
	tdist_t far_d;
	logic outside_d;

	// latest entry and earliest exit over the three slabs
	assign near_xy = t_max(span_x.t_enter, span_y.t_enter);
	assign near_d = t_max(near_xy, span_z.t_enter);
	assign far_xy = t_min(span_x.t_exit, span_y.t_exit);
	assign far_d = t_min(far_xy, span_z.t_exit);

	// any parallel axis out of its slab kills the hit
	assign outside_d = span_x.outside | span_y.outside | span_z.outside;

	logic s3_valid;
	tdist_t s3_near;
	tdist_t s3_far;
	logic s3_outside;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s3_valid <= 1'b0;
		end else begin
			s3_valid <= span_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (span_valid) begin
			s3_near <= near_d;
			s3_far <= far_d;
			s3_outside <= outside_d;
		end
	end

	////////////////////
	// stage 4 decide
	////////////////////

	logic overlap; // far at least near, tie counts
	logic ahead; // exit strictly in front of the origin
	logic hit_d;

	assign overlap = s3_far >= s3_near;
	assign ahead = s3_far > T_ZERO;
	assign hit_d = !s3_outside && overlap && ahead;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= s3_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s3_valid) begin
			hit <= hit_d; // held between results
		end
	end

endmodule

/* logic/ray_box_top.sv */
`timescale 1ns/1ps
`include "ray_box_macros.svh"

module ray_box_top
	import ray_box_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input ray_query_t query,
	output logic out_valid,
	output logic hit
);

	////////////////////
	// per axis slabs
	////////////////////

	axis_span_t span_x;
	axis_span_t span_y;
	axis_span_t span_z;
	logic span_valid; // same timing on all three axes

	axis_slab u_slab_x (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.axq (query.qx),
		.span (span_x),
		.span_valid (span_valid) // x carries the valid for all
	);

	axis_slab u_slab_y (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.axq (query.qy),
		.span (span_y),
		.span_valid () // twin of the x valid
	);

	axis_slab u_slab_z (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.axq (query.qz),
		.span (span_z),
		.span_valid () // twin of the x valid
	);

	////////////////////
	// merge and decide
	////////////////////

	// two more stages, four in all
	interval_intersect u_merge (
		.clk (clk),
		.rst (rst),
		.span_valid (span_valid),
		.span_x (span_x),
		.span_y (span_y),
		.span_z (span_z),
		.out_valid (out_valid),
		.hit (hit)
	);

endmodule

/* tb/tb_ray_box.sv */
`timescale 1ns/1ps
`include "ray_box_macros.svh"

module tb_ray_box
	import ray_box_pkg::*;
();

	localparam int CLK_HALF = 5;
	localparam int RESET_CYC = 5;
	localparam int N_RAND = 200;
	localparam longint T_LO = -(longint'(1) << (`T_W-1)); // open slab bounds
	localparam longint T_HI = (longint'(1) << (`T_W-1)) - 1;

	logic clk;
	logic rst;
	logic in_valid;
	ray_query_t query;
	logic out_valid;
	logic hit;

	int edge_cnt = 0; // rising edges so far
	int n_dir = 0;
	bit vec_ready = 1'b0;
	ray_query_t dir_vec[$];
	logic dir_exp[$];
	logic exp_q[$]; // expected hit, oldest first
	int due_q[$]; // edge that must raise out_valid

	ray_box_top uut (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.query (query),
		.out_valid (out_valid),
		.hit (hit)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	////////////////////
	// reference model
	////////////////////

	function automatic axis_query_t make_axis(input int o, input int mn, input int mx,
			input int inv, input int par);
		axis_query_t a;
		a.origin = coord_t'(o);
		a.box_min = coord_t'(mn);
		a.box_max = coord_t'(mx);
		a.inv = inv_t'(inv);
		a.parallel = par[0];
		return a;
	endfunction

	function automatic logic expect_hit(input ray_query_t q);
		axis_query_t ax [3];
		longint p_min;
		longint p_max;
		longint near_t;
		longint far_t;
		bit outside;
		ax[0] = q.qx;
		ax[1] = q.qy;
		ax[2] = q.qz;
		near_t = T_LO;
		far_t = T_HI;
		outside = 1'b0;
		for (int i = 0; i < 3; i++) begin
			p_min = (longint'($signed(ax[i].box_min)) - longint'($signed(ax[i].origin)))
				* longint'($signed(ax[i].inv));
			p_max = (longint'($signed(ax[i].box_max)) - longint'($signed(ax[i].origin)))
				* longint'($signed(ax[i].inv));
			if (ax[i].parallel) begin
				// no distance limit, only the inside test
				if ($signed(ax[i].origin) < $signed(ax[i].box_min) ||
						$signed(ax[i].origin) > $signed(ax[i].box_max))
					outside = 1'b1;
			end else if ($signed(ax[i].inv) < 0) begin
				if (p_max > near_t) near_t = p_max; // max plane reached first
				if (p_min < far_t) far_t = p_min;
			end else begin
				if (p_min > near_t) near_t = p_min;
				if (p_max < far_t) far_t = p_max;
			end
		end
		return !outside && (far_t >= near_t) && (far_t > 0);
	endfunction

	function automatic ray_query_t random_query();
		ray_query_t q;
		axis_query_t ax [3];
		int mn;
		for (int i = 0; i < 3; i++) begin
			mn = int'($urandom_range(127)) - 64;
			ax[i] = make_axis(int'($urandom_range(127)) - 64, mn,
				mn + int'($urandom_range(40)), int'($urandom_range(1023)) - 512,
				($urandom_range(7) == 0) ? 1 : 0); // parallel about 1 in 8
		end
		q.qx = ax[0];
		q.qy = ax[1];
		q.qz = ax[2];
		return q;
	endfunction

	////////////////////
	// compare tasks
	////////////////////

	task automatic check_valid(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: out_valid expected %b actual %b",
				$time, expected, actual);
			$display("Test failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic check_hit(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: hit expected %b actual %b",
				$time, expected, actual);
			$display("Test failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// values read here were set by the previous rising edge
	always @(posedge clk) begin
		edge_cnt = edge_cnt + 1;
		if (!rst) begin
			if (due_q.size() > 0 && due_q[0] == edge_cnt - 1) begin
				check_valid(1'b1, out_valid);
				check_hit(exp_q[0], hit);
				void'(due_q.pop_front());
				void'(exp_q.pop_front());
			end else begin
				check_valid(1'b0, out_valid); // gaps and idle stay low
			end
		end
	end

	////////////////////
	// stimulus
	////////////////////

	task automatic send(input ray_query_t q, input logic expected);
		@(negedge clk);
		in_valid = 1'b1;
		query = q;
		exp_q.push_back(expected);
		due_q.push_back(edge_cnt + `PIPE_LAT);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			in_valid = 1'b0;
			query = '0;
		end
	endtask

	initial begin
		int fd;
		int n;
		string line;
		int v [16];
		ray_query_t q;
		void'($urandom(32'hb2ef));
		rst = 1'b1;
		in_valid = 1'b0;
		query = '0;
		fd = $fopen("tb/ray_box_input.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/ray_box_input.txt");
			$display("Test failed");
			$fatal(1, "no stimulus file");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.substr(0, 0) != "#") begin
				n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
					v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
				if (n == 16) begin
					q.qx = make_axis(v[0], v[1], v[2], v[3], v[4]);
					q.qy = make_axis(v[5], v[6], v[7], v[8], v[9]);
					q.qz = make_axis(v[10], v[11], v[12], v[13], v[14]);
					dir_vec.push_back(q);
					dir_exp.push_back(v[15] != 0);
				end
			end
		end
		$fclose(fd);
		n_dir = dir_vec.size();
		vec_ready = 1'b1;
		if (n_dir == 0) begin
			$display("no directed vectors found in tb/ray_box_input.txt");
			$display("Test failed");
			$fatal(1, "empty stimulus file");
		end
		repeat (RESET_CYC) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		idle(4); // out_valid must stay low here
		for (int i = 0; i < n_dir; i++) begin
			send(dir_vec[i], dir_exp[i]);
			if (i % 6 == 5) idle(1); // break the burst now and then
		end
		idle(2);
		for (int i = 0; i < N_RAND; i++) begin
			q = random_query();
			send(q, expect_hit(q));
			if ($urandom_range(3) == 0) idle(1);
		end
		idle(`PIPE_LAT + 3);
		if (exp_q.size() == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("%0d results never arrived", exp_q.size());
			$display("Test failed");
			$fatal(1, "missing results");
		end
	end

	// worst case is one idle cycle after every query
	initial begin
		int limit;
		wait (vec_ready);
		limit = RESET_CYC + 10 + 2 * (n_dir + N_RAND) + `PIPE_LAT + 20;
		repeat (limit) @(posedge clk);
		$display("timeout, run did not finish within %0d cycles", limit);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* compile.f */
+incdir+include
logic/ray_box_pkg.sv
logic/axis_slab.sv
logic/interval_intersect.sv
logic/ray_box_top.sv
tb/tb_ray_box.sv

/* Makefile */
TOP = tb_ray_box
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f compile.f -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tb/ray_box_input.txt */
# x: origin min max inv par | y: origin min max inv par | z: origin min max inv par | hit
# inv is Q8.8 (256 = 1.0), par is the parallel flag, hit is the expected result
0 10 20 256 0      0 5 15 256 0        0 0 30 128 0        1
50 10 20 -256 0    20 0 40 0 1         5 0 10 0 1          1
0 10 20 256 0      0 30 40 256 0       0 -5 5 0 1          0
0 10 20 256 0      0 -40 -30 256 0     0 -5 5 0 1          0
0 10 20 256 0      3 0 10 0 1          10 0 10 0 1         1
0 10 20 256 0      11 0 10 0 1         5 0 10 0 1          0
0 10 20 256 0      3 0 10 0 1          -1 0 10 0 1         0
5 0 10 -300 1      0 10 20 256 0       0 0 0 0 1           1
50 10 20 256 0     5 0 10 0 1          5 0 10 0 1          0
20 10 20 256 0     5 0 10 0 1          5 0 10 0 1          0
15 10 20 256 0     5 0 10 -256 0       0 -10 10 512 0      1
0 10 20 256 0      0 20 30 256 0       0 0 0 0 1           1
0 10 20 0 0        5 0 10 0 1          5 0 10 0 1          0
-32768 32767 32767 32767 0   32767 -32768 -32768 -32768 0   0 -1 1 0 1   0
-32768 32767 32767 32767 0   0 -32768 32767 0 1   32767 -32768 32767 0 1   1
0 -20 -10 -256 0   5 0 10 0 1          5 0 10 0 1          1
